// File: source/uart_frame_pkg.sv
// framed-string UART constants
// character codes, string geometry and baud timing shared by the design

package uart_frame_pkg;

	// string geometry
	localparam int MAX_CHARS = 16;
	localparam int STRING_W  = MAX_CHARS * 8;
	localparam int LEN_W     = 8;

	// clock and line rate, 40 ns clock
	localparam int CLK_FREQ_HZ  = 25_000_000;
	localparam int BAUD_RATE    = 1_562_500;
	localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;
	localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);

	// frame delimiter, two of these open and two close a frame
	localparam logic [7:0] FRAME_CHAR = 8'h26;

endpackage

// File: source/baud_timer.sv
// baud timer
// pulses tick once per bit period while run is high, with an optional
// half-period first interval for mid-bit sampling

`timescale 1ns/100ps

module baud_timer
	import uart_frame_pkg::*;
(
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic run,
	input  logic half_first,
	output logic tick
);

	localparam logic [BAUD_CNT_W-1:0] FULL_LAST = BAUD_CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [BAUD_CNT_W-1:0] HALF_LAST = BAUD_CNT_W'(CLKS_PER_BIT / 2 - 1);

	logic [BAUD_CNT_W-1:0] cnt;
	logic                  half_q;

	assign tick = run && (cnt == (half_q ? HALF_LAST : FULL_LAST));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			cnt    <= '0;
			half_q <= 1'b0;
		end else if (!run) begin
			// armed for the next run while idle
			cnt    <= '0;
			half_q <= half_first;
		end else if (tick) begin
			cnt    <= '0;
			half_q <= 1'b0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

// File: source/uart_tx.sv
// UART transmitter, 8N1
// shifts out start bit, eight data bits lsb first and one stop bit,
// then pulses byte_done

`timescale 1ns/100ps

module uart_tx (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] byte_data,
	input  logic       byte_start,
	output logic       tx_line,
	output logic       byte_done
);

	logic [9:0] shift_q;
	logic [3:0] bit_cnt;
	logic       busy;
	logic       tick;

	baud_timer u_baud_timer (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.run        (busy),
		.half_first (1'b0),
		.tick       (tick)
	);

	// all ones when idle keeps the line high
	assign tx_line = shift_q[0];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			shift_q   <= '1;
			bit_cnt   <= '0;
			busy      <= 1'b0;
			byte_done <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			if (!busy) begin
				if (byte_start) begin
					// stop, data, start
					shift_q <= {1'b1, byte_data, 1'b0};
					bit_cnt <= '0;
					busy    <= 1'b1;
				end
			end else if (tick) begin
				shift_q <= {1'b1, shift_q[9:1]};
				if (bit_cnt == 4'd9) begin
					busy      <= 1'b0;
					byte_done <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

endmodule

// File: source/uart_rx.sv
// UART receiver, 8N1
// synchronizes the line, samples each bit at mid-period and
// presents a byte with rx_vld when the stop bit reads high

`timescale 1ns/100ps

module uart_rx (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       rx_line,
	output logic [7:0] rx_byte,
	output logic       rx_vld
);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t  state;
	logic       rx_s1;
	logic       rx_s2;
	logic       rx_prev;
	logic [2:0] bit_cnt;
	logic [7:0] shift_q;
	logic       tick;

	baud_timer u_baud_timer (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.run        (state != RX_IDLE),
		.half_first (1'b1),
		.tick       (tick)
	);

	// two-stage synchronizer plus one stage for edge detect
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_s1   <= 1'b1;
			rx_s2   <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_s1   <= rx_line;
			rx_s2   <= rx_s1;
			rx_prev <= rx_s2;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= RX_IDLE;
			bit_cnt <= '0;
			rx_vld  <= 1'b0;
		end else begin
			rx_vld <= 1'b0;
			case (state)
				RX_IDLE:
					if (rx_prev && !rx_s2)
						state <= RX_START;
				RX_START:
					if (tick) begin
						// still high at mid-bit, treat as glitch
						state   <= rx_s2 ? RX_IDLE : RX_DATA;
						bit_cnt <= '0;
					end
				RX_DATA:
					if (tick) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= RX_STOP;
					end
				RX_STOP:
					if (tick) begin
						state  <= RX_IDLE;
						rx_vld <= rx_s2;
					end
				default:
					state <= RX_IDLE;
			endcase
		end
	end

	// data path, qualified by rx_vld
	always_ff @(posedge sys_clk) begin
		if (state == RX_DATA && tick)
			shift_q <= {rx_s2, shift_q[7:1]};
		if (state == RX_STOP && tick)
			rx_byte <= shift_q;
	end

endmodule

// File: source/frame_tx_fsm.sv
// frame transmit sequencer
// sends '&&', the payload bytes and '&&' through the byte serializer,
// one byte_start per byte_done

`timescale 1ns/100ps

module frame_tx_fsm
	import uart_frame_pkg::*;
(
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	input  logic [STRING_W-1:0] tx_string,
	input  logic [LEN_W-1:0]    tx_length,
	input  logic                tx_req,
	output logic                tx_busy,
	output logic                tx_done,
	output logic [7:0]          byte_data,
	output logic                byte_start,
	input  logic                byte_done
);

	typedef enum logic [2:0] {
		S_IDLE, S_SIGN1, S_SIGN2, S_CONTENT, S_SIGN3, S_SIGN4, S_FINISH
	} tx_state_t;

	tx_state_t        state;
	logic [LEN_W-1:0] len_q;
	logic [LEN_W-1:0] len_clamp;
	logic [LEN_W-1:0] byte_cnt;

	assign len_clamp = (tx_length > LEN_W'(MAX_CHARS)) ? LEN_W'(MAX_CHARS) : tx_length;

	// busy drops on the finish cycle, together with the done pulse
	assign tx_busy = (state != S_IDLE) && (state != S_FINISH);
	assign tx_done = (state == S_FINISH);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state      <= S_IDLE;
			len_q      <= '0;
			byte_cnt   <= '0;
			byte_data  <= '0;
			byte_start <= 1'b0;
		end else begin
			byte_start <= 1'b0;
			case (state)
				S_IDLE, S_FINISH:
					if (tx_req) begin
						state      <= S_SIGN1;
						len_q      <= len_clamp;
						byte_cnt   <= '0;
						byte_data  <= FRAME_CHAR;
						byte_start <= 1'b1;
					end else begin
						state <= S_IDLE;
					end
				S_SIGN1:
					if (byte_done) begin
						state      <= S_SIGN2;
						byte_data  <= FRAME_CHAR;
						byte_start <= 1'b1;
					end
				S_SIGN2:
					if (byte_done) begin
						byte_start <= 1'b1;
						if (len_q == '0) begin
							// empty payload
							state     <= S_SIGN3;
							byte_data <= FRAME_CHAR;
						end else begin
							state     <= S_CONTENT;
							byte_data <= tx_string[7:0];
							byte_cnt  <= LEN_W'(1);
						end
					end
				S_CONTENT:
					if (byte_done) begin
						byte_start <= 1'b1;
						if (byte_cnt == len_q) begin
							state     <= S_SIGN3;
							byte_data <= FRAME_CHAR;
						end else begin
							byte_data <= tx_string[byte_cnt*8 +: 8];
							byte_cnt  <= byte_cnt + 1'b1;
						end
					end
				S_SIGN3:
					if (byte_done) begin
						state      <= S_SIGN4;
						byte_data  <= FRAME_CHAR;
						byte_start <= 1'b1;
					end
				S_SIGN4:
					if (byte_done)
						state <= S_FINISH;
				default:
					state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: source/frame_rx_fsm.sv
// frame receive state machine
// hunts for '&&', collects payload bytes into rx_string and reports
// the length on the closing '&&', or drops a bad frame with rx_error

`timescale 1ns/100ps

module frame_rx_fsm
	import uart_frame_pkg::*;
(
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	input  logic [7:0]          rx_byte,
	input  logic                rx_vld,
	output logic [STRING_W-1:0] rx_string,
	output logic [LEN_W-1:0]    rx_length,
	output logic                rx_busy,
	output logic                rx_done,
	output logic                rx_error
);

	typedef enum logic [1:0] {R_HUNT, R_SIGN1, R_CONTENT, R_CLOSE} rx_state_t;

	rx_state_t        state;
	logic [LEN_W-1:0] byte_cnt;
	logic             is_sign;

	assign is_sign = (rx_byte == FRAME_CHAR);
	assign rx_busy = (state != R_HUNT);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= R_HUNT;
			byte_cnt  <= '0;
			rx_length <= '0;
			rx_done   <= 1'b0;
			rx_error  <= 1'b0;
		end else begin
			rx_done  <= 1'b0;
			rx_error <= 1'b0;
			if (rx_vld) begin
				case (state)
					R_HUNT:
						if (is_sign)
							state <= R_SIGN1;
					R_SIGN1: begin
						// a lone '&' before the frame is just noise
						state    <= is_sign ? R_CONTENT : R_HUNT;
						byte_cnt <= '0;
					end
					R_CONTENT:
						if (is_sign) begin
							state <= R_CLOSE;
						end else if (byte_cnt == LEN_W'(MAX_CHARS)) begin
							state    <= R_HUNT;
							rx_error <= 1'b1;
						end else begin
							byte_cnt <= byte_cnt + 1'b1;
						end
					R_CLOSE: begin
						state <= R_HUNT;
						if (is_sign) begin
							rx_length <= byte_cnt;
							rx_done   <= 1'b1;
						end else begin
							rx_error <= 1'b1;
						end
					end
					default:
						state <= R_HUNT;
				endcase
			end
		end
	end

	// string store, cleared on the opening '&'
	always_ff @(posedge sys_clk) begin
		if (rx_vld && state == R_HUNT && is_sign)
			rx_string <= '0;
		else if (rx_vld && state == R_CONTENT && !is_sign && byte_cnt < LEN_W'(MAX_CHARS))
			rx_string[byte_cnt*8 +: 8] <= rx_byte;
	end

endmodule

// File: source/uart_frame_top.sv
// framed-string UART transceiver
// transmit sequencer and serializer on one line, deserializer and
// frame receiver on the other

`timescale 1ns/100ps

module uart_frame_top
	import uart_frame_pkg::*;
(
	input  logic                sys_clk,
	input  logic                sys_rst_n,

	input  logic [STRING_W-1:0] tx_string,
	input  logic [LEN_W-1:0]    tx_length,
	input  logic                tx_req,
	output logic                tx_busy,
	output logic                tx_done,

	output logic [STRING_W-1:0] rx_string,
	output logic [LEN_W-1:0]    rx_length,
	output logic                rx_busy,
	output logic                rx_done,
	output logic                rx_error,

	input  logic                uart_rx_port,
	output logic                uart_tx_port
);

	logic [7:0] byte_data;
	logic       byte_start;
	logic       byte_done;
	logic [7:0] rx_byte;
	logic       rx_vld;

	frame_tx_fsm u_frame_tx_fsm (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.tx_string  (tx_string),
		.tx_length  (tx_length),
		.tx_req     (tx_req),
		.tx_busy    (tx_busy),
		.tx_done    (tx_done),
		.byte_data  (byte_data),
		.byte_start (byte_start),
		.byte_done  (byte_done)
	);

	uart_tx u_uart_tx (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.byte_data  (byte_data),
		.byte_start (byte_start),
		.tx_line    (uart_tx_port),
		.byte_done  (byte_done)
	);

	uart_rx u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_line   (uart_rx_port),
		.rx_byte   (rx_byte),
		.rx_vld    (rx_vld)
	);

	frame_rx_fsm u_frame_rx_fsm (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_byte   (rx_byte),
		.rx_vld    (rx_vld),
		.rx_string (rx_string),
		.rx_length (rx_length),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done),
		.rx_error  (rx_error)
	);

endmodule

// File: dv/uart_frame_props.sv
// frame state machine properties
// handshake checks bound into both frame state machines

`timescale 1ns/100ps

module uart_frame_props (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic tx_busy,
	input logic tx_done,
	input logic byte_start,
	input logic byte_done,
	input logic rx_done,
	input logic rx_error
);

	int   assert_fails = 0;
	logic byte_pending;

	// a byte is in flight from byte_start until its byte_done
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			byte_pending <= 1'b0;
		else if (byte_start)
			byte_pending <= 1'b1;
		else if (byte_done)
			byte_pending <= 1'b0;
	end

	done_after_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |-> $past(tx_busy))
		else begin
			$error("tx_done without tx_busy on the prior cycle");
			assert_fails++;
		end

	done_xor_error: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!(rx_done && rx_error))
		else begin
			$error("rx_done and rx_error high together");
			assert_fails++;
		end

	no_start_in_flight: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		byte_start |-> !byte_pending)
		else begin
			$error("byte_start raised before byte_done of the previous byte");
			assert_fails++;
		end

endmodule

bind frame_tx_fsm uart_frame_props u_props (
	.sys_clk    (sys_clk),
	.sys_rst_n  (sys_rst_n),
	.tx_busy    (tx_busy),
	.tx_done    (tx_done),
	.byte_start (byte_start),
	.byte_done  (byte_done),
	.rx_done    (1'b0),
	.rx_error   (1'b0)
);

bind frame_rx_fsm uart_frame_props u_props (
	.sys_clk    (sys_clk),
	.sys_rst_n  (sys_rst_n),
	.tx_busy    (1'b0),
	.tx_done    (1'b0),
	.byte_start (1'b0),
	.byte_done  (1'b0),
	.rx_done    (rx_done),
	.rx_error   (rx_error)
);

// File: dv/tb_uart_frame.sv
// testbench for the framed-string UART transceiver
// loopback and raw serial frames read from a vector file, checked
// against lengths and payloads derived from the framing rules

`timescale 1ns/100ps

module tb_uart_frame
	import uart_frame_pkg::*;
();

	localparam int CHAR_CLKS   = 10 * CLKS_PER_BIT;
	localparam int SETTLE_CLKS = 2 * CHAR_CLKS;
	localparam int RESULT_CLKS = (MAX_CHARS + 6) * CHAR_CLKS;
	localparam int MAX_TESTS   = 32;

	logic                sys_clk;
	logic                sys_rst_n;
	logic [STRING_W-1:0] tx_string;
	logic [LEN_W-1:0]    tx_length;
	logic                tx_req;
	logic                tx_busy;
	logic                tx_done;
	logic [STRING_W-1:0] rx_string;
	logic [LEN_W-1:0]    rx_length;
	logic                rx_busy;
	logic                rx_done;
	logic                rx_error;
	logic                uart_tx_port;
	logic                uart_rx_port;
	logic                loop_mode;
	logic                serial_line;

	logic [7:0]   t_mode [MAX_TESTS];
	int           t_len  [MAX_TESTS];
	logic [255:0] t_data [MAX_TESTS];
	int           t_code [MAX_TESTS];
	int           t_exp  [MAX_TESTS];
	int           n_tests = 0;
	logic         tests_loaded = 1'b0;

	int error_count = 0;
	int check_count = 0;
	int done_seen = 0;
	int error_seen = 0;
	int tx_done_seen = 0;
	int busy_cycles = 0;
	int assert_fails;

	// loopback ties the receiver to the transmitter
	assign uart_rx_port = loop_mode ? uart_tx_port : serial_line;

	uart_frame_top uut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.rx_error     (rx_error),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	// pulse and busy counters, sampled mid-cycle
	always @(negedge sys_clk) begin
		if (rx_done)
			done_seen++;
		if (rx_error)
			error_seen++;
		if (tx_done)
			tx_done_seen++;
		if (rx_busy)
			busy_cycles++;
	end

	task automatic check_value(input logic [STRING_W-1:0] actual,
			input logic [STRING_W-1:0] expected, input string what);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("[FAIL] %0t: %s: got %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	task automatic load_tests();
		int              fd;
		int              c;
		int              r;
		int              len;
		int              code;
		int              exp_len;
		logic [255:0]    data;
		logic [8*200-1:0] line_buf;
		fd = $fopen("dv/frame_tests.txt", "r");
		if (fd == 0) begin
			error_count++;
			$display("could not open the test vector file dv/frame_tests.txt");
		end else begin
			c = $fgetc(fd);
			while (c != -1) begin
				if (c == "#") begin
					r = $fgets(line_buf, fd);
				end else if ((c == "L" || c == "S") && n_tests < MAX_TESTS) begin
					r = $fscanf(fd, "%d %h %d %d", len, data, code, exp_len);
					if (r == 4) begin
						t_mode[n_tests] = c[7:0];
						t_len[n_tests]  = len;
						t_data[n_tests] = data;
						t_code[n_tests] = code;
						t_exp[n_tests]  = exp_len;
						n_tests++;
					end else begin
						error_count++;
						$display("malformed test vector line after test %0d", n_tests);
					end
				end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
					error_count++;
					$display("unexpected character %0d in the test vector file", c);
				end
				c = $fgetc(fd);
			end
			$fclose(fd);
		end
		if (n_tests == 0) begin
			error_count++;
			$display("no test vectors were loaded");
		end
		tests_loaded = 1'b1;
	endtask

	task automatic hold_bit();
		repeat (CLKS_PER_BIT) @(posedge sys_clk);
		#2;
	endtask

	// 8N1, lsb first
	task automatic send_byte(input logic [7:0] value);
		int b;
		serial_line = 1'b0;
		hold_bit();
		for (b = 0; b < 8; b++) begin
			serial_line = value[b];
			hold_bit();
		end
		serial_line = 1'b1;
		hold_bit();
	endtask

	task automatic run_serial(input int idx);
		int i;
		loop_mode = 1'b0;
		for (i = 0; i < t_len[idx]; i++)
			send_byte(t_data[idx][8*i +: 8]);
	endtask

	task automatic run_loopback(input int idx);
		int waited;
		int tx_base;
		loop_mode = 1'b1;
		tx_string = t_data[idx][STRING_W-1:0];
		tx_length = LEN_W'(t_len[idx]);
		tx_base   = tx_done_seen;
		tx_req    = 1'b1;
		@(posedge sys_clk);
		#2;
		tx_req = 1'b0;
		@(negedge sys_clk);
		check_value(tx_busy, 1'b1, $sformatf("test %0d tx_busy after tx_req", idx));
		// a second request mid-frame must be ignored
		repeat (CHAR_CLKS) @(posedge sys_clk);
		#2;
		tx_req = 1'b1;
		@(posedge sys_clk);
		#2;
		tx_req = 1'b0;
		waited = 0;
		while (tx_done_seen == tx_base && waited < RESULT_CLKS) begin
			@(posedge sys_clk);
			waited++;
		end
		if (tx_done_seen == tx_base) begin
			error_count++;
			$display("test %0d: tx_done never arrived", idx);
		end
	endtask

	task automatic wait_result(input int idx, input int done_base, input int err_base);
		int waited;
		waited = 0;
		while (done_seen == done_base && error_seen == err_base && waited < RESULT_CLKS) begin
			@(posedge sys_clk);
			waited++;
		end
		if (done_seen == done_base && error_seen == err_base) begin
			error_count++;
			$display("test %0d: neither rx_done nor rx_error arrived in time", idx);
		end
		// long enough for a spurious extra frame to show up
		repeat (SETTLE_CLKS) @(posedge sys_clk);
		#2;
	endtask

	// payload byte i: from tx_string, or just before the closing '&&'
	function automatic logic [7:0] expected_byte(input int idx, input int i);
		if (t_mode[idx] == "L")
			return t_data[idx][8*i +: 8];
		return t_data[idx][8*(t_len[idx] - 2 - t_exp[idx] + i) +: 8];
	endfunction

	task automatic check_result(input int idx, input int done_base, input int err_base);
		logic [STRING_W-1:0] exp_str;
		int                  i;
		exp_str = '0;
		for (i = 0; i < t_exp[idx]; i++)
			exp_str[8*i +: 8] = expected_byte(idx, i);
		if (t_code[idx] == 0) begin
			check_value(done_seen - done_base, 1, $sformatf("test %0d rx_done count", idx));
			check_value(error_seen - err_base, 0, $sformatf("test %0d rx_error count", idx));
			check_value(rx_length, t_exp[idx], $sformatf("test %0d rx_length", idx));
			check_value(rx_string, exp_str, $sformatf("test %0d rx_string", idx));
		end else begin
			check_value(done_seen - done_base, 0, $sformatf("test %0d rx_done count", idx));
			check_value(error_seen - err_base, 1, $sformatf("test %0d rx_error count", idx));
		end
		check_value(rx_busy, 1'b0, $sformatf("test %0d rx_busy at end", idx));
		check_value(tx_busy, 1'b0, $sformatf("test %0d tx_busy at end", idx));
	endtask

	initial begin
		int idx;
		int done_base;
		int err_base;
		int busy_base;
		sys_rst_n   = 1'b0;
		tx_string   = '0;
		tx_length   = '0;
		tx_req      = 1'b0;
		loop_mode   = 1'b0;
		serial_line = 1'b1;
		void'($urandom(32'he8c7));
		load_tests();
		repeat (3) @(posedge sys_clk);
		#2;
		sys_rst_n = 1'b1;
		@(negedge sys_clk);
		check_value(tx_busy, 1'b0, "tx_busy after reset");
		check_value(tx_done, 1'b0, "tx_done after reset");
		check_value(rx_busy, 1'b0, "rx_busy after reset");
		check_value(rx_done, 1'b0, "rx_done after reset");
		check_value(rx_error, 1'b0, "rx_error after reset");
		check_value(uart_tx_port, 1'b1, "uart_tx_port idle after reset");
		for (idx = 0; idx < n_tests; idx++) begin
			repeat ($urandom % 8 + 2) @(posedge sys_clk);
			#2;
			done_base = done_seen;
			err_base  = error_seen;
			busy_base = busy_cycles;
			if (t_mode[idx] == "L")
				run_loopback(idx);
			else
				run_serial(idx);
			wait_result(idx, done_base, err_base);
			check_result(idx, done_base, err_base);
			// every vector opens at least one frame
			check_value(busy_cycles != busy_base, 1'b1,
				$sformatf("test %0d rx_busy raised during frame", idx));
		end
		assert_fails = uut.u_frame_tx_fsm.u_props.assert_fails +
			uut.u_frame_rx_fsm.u_props.assert_fails;
		$display("tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
			n_tests, check_count, error_count, assert_fails);
		if (error_count == 0 && assert_fails == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	// watchdog sized from the number of tests
	initial begin
		wait (tests_loaded);
		repeat (n_tests * (MAX_CHARS + 8) * CHAR_CLKS + 2000) @(posedge sys_clk);
		$display("watchdog: the run timed out before all tests completed");
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: build.f
source/uart_frame_pkg.sv
source/baud_timer.sv
source/uart_tx.sv
source/uart_rx.sv
source/frame_tx_fsm.sv
source/frame_rx_fsm.sv
source/uart_frame_top.sv
dv/uart_frame_props.sv
dv/tb_uart_frame.sv

// File: Bender.yml
package:
  name: uart_frame

sources:
  - source/uart_frame_pkg.sv
  - source/baud_timer.sv
  - source/uart_tx.sv
  - source/uart_rx.sv
  - source/frame_tx_fsm.sv
  - source/frame_rx_fsm.sv
  - source/uart_frame_top.sv
  - target: simulation
    files:
      - dv/uart_frame_props.sv
      - dv/tb_uart_frame.sv

// File: dv/frame_tests.txt
# columns: mode length hex_bytes result expected_length
# L = loopback with tx_length, S = raw serial bytes; byte 0 rightmost; result 0 done, 1 error
L 1 41 0 1
L 5 6f6c6c6568 0 5
L 16 66656463626139383736353433323130 0 16
L 20 504f4e4d4c4b4a494847464544434241 0 16
L 0 00 0 0
S 4 26262626 0 0
S 10 26266968262661267978 0 2
S 7 64632662612626 1 0
S 6 26266b6f2626 0 2
S 19 71706f6e6d6c6b6a6968676665646362612626 1 0
S 6 26266b6f2626 0 2
